// File: src/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_ways       = 4;
    localparam int num_sets       = 128;
    localparam int set_bits       = 7;
    localparam int tag_bits       = 20;
    localparam int words_per_line = 8;
    localparam int half_bits      = 128;
    localparam int line_bits      = 256;

    // the refill always uses one fixed AXI read burst
    // WRAP type, eight beats of 4 bytes, id 0, normal unprotected access
    // so arlen, arsize, arburst and the other constant fields are not ports

    ////////////////////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_reset,
        st_run,
        st_miss,
        st_refill,
        st_finish,
        st_replay
    } cache_state_t;

    typedef logic [num_ways-1:0] way_mask_t;

    // bit0 picks the pair, bit1 inside ways 0/1, bit2 inside ways 2/3
    typedef logic [2:0] plru_t;

    typedef struct packed {
        logic [set_bits-1:0] set_idx;
        logic                half;
    } lookup_t;

    typedef struct packed {
        way_mask_t           ways;
        logic [set_bits-1:0] set_idx;
        logic [tag_bits-1:0] tag;
        logic                valid;
    } tag_write_t;

    typedef struct packed {
        way_mask_t            ways;
        logic [set_bits-1:0]  set_idx;
        logic [line_bits-1:0] line;
    } data_write_t;

endpackage

// File: src/tag_ways.sv
`timescale 1ns/1ps

module tag_ways
    import icache_pkg::*;
(
    input  logic                clk,
    input  lookup_t             rd,
    input  logic [tag_bits-1:0] cmp_tag,
    input  tag_write_t          wr,
    output way_mask_t           hit
);

    // tag and valid per set, one array per way
    logic [tag_bits-1:0] tag_mem   [num_ways][num_sets];
    logic                valid_mem [num_ways][num_sets];

    // registered read of the looked-up set
    logic [tag_bits-1:0] tag_q   [num_ways];
    logic                valid_q [num_ways];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (wr.ways[w]) begin
                tag_mem[w][wr.set_idx]   <= wr.tag;
                valid_mem[w][wr.set_idx] <= wr.valid;
            end
        end
    end

    // a write to the set being read shows up in the read result right away,
    // so the replay after a fill sees the new line
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (wr.ways[w] && (wr.set_idx == rd.set_idx)) begin
                tag_q[w]   <= wr.tag;
                valid_q[w] <= wr.valid;
            end else begin
                tag_q[w]   <= tag_mem[w][rd.set_idx];
                valid_q[w] <= valid_mem[w][rd.set_idx];
            end
        end
    end

    // compare against the tag of the request in the tag stage
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
        end
    end

    // a tag lives in one way only; relies on the controller filling a set
    // only after that tag missed in every way
    assert property (@(posedge clk) !$isunknown(hit) |-> $onehot0(hit))
        else $error("tag_ways: more than one way hit, mask %b", hit);

endmodule

// File: src/data_ways.sv
`timescale 1ns/1ps

module data_ways
    import icache_pkg::*;
(
    input  logic                               clk,
    input  lookup_t                            rd,
    input  data_write_t                        wr,
    output logic [num_ways-1:0][half_bits-1:0] half_data
);

    // full lines, one array per way
    logic [line_bits-1:0] line_mem [num_ways][num_sets];

    // registered read
    logic [line_bits-1:0] line_q [num_ways];
    logic                 half_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (wr.ways[w]) begin
                line_mem[w][wr.set_idx] <= wr.line;
            end
        end
    end

    // same forwarding as the tag side so a fresh line reads back at once
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (wr.ways[w] && (wr.set_idx == rd.set_idx)) begin
                line_q[w] <= wr.line;
            end else begin
                line_q[w] <= line_mem[w][rd.set_idx];
            end
        end
        half_q <= rd.half;
    end

    // upper half holds words 4..7
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            if (half_q) begin
                half_data[w] = line_q[w][line_bits-1:half_bits];
            end else begin
                half_data[w] = line_q[w][half_bits-1:0];
            end
        end
    end

endmodule

// File: src/miss_ctrl.sv
`timescale 1ns/1ps

module miss_ctrl
    import icache_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    // cpu side
    input  logic                               req,
    input  lookup_t                            index,
    input  logic [tag_bits-1:0]                tag,
    output logic                               index_ok,
    output logic                               data_ok,
    output logic [half_bits-1:0]               rdata,
    // axi read channel
    output logic [31:0]                        araddr,
    output logic                               arvalid,
    input  logic                               arready,
    input  logic [31:0]                        rdata_bus,
    input  logic                               rvalid,
    input  logic                               rlast,
    output logic                               rready,
    // tag arrays
    output lookup_t                            tag_rd,
    output logic [tag_bits-1:0]                cmp_tag,
    output tag_write_t                         tag_wr,
    input  way_mask_t                          hit,
    // data arrays
    output lookup_t                            data_rd,
    output data_write_t                        data_wr,
    input  logic [num_ways-1:0][half_bits-1:0] half_data
);

    cache_state_t        state;
    logic [set_bits-1:0] reset_cnt;

    // tag stage
    logic    ts_valid;
    lookup_t ts_lookup;

    // data stage
    logic                 ds_valid;
    lookup_t              ds_lookup;
    logic [tag_bits-1:0]  ds_tag;
    way_mask_t            ds_hit;
    logic [half_bits-1:0] ds_data;

    // refill
    way_mask_t                            victim;
    plru_t                                plru [num_sets];
    logic [$clog2(words_per_line)-1:0]    fill_cnt;
    logic [31:0]                          fill_buf [words_per_line];
    logic [line_bits-1:0]                 fill_line;

    logic                 ds_adv;
    logic                 ds_miss;
    logic                 beat;
    logic [half_bits-1:0] hit_half;

    function automatic way_mask_t plru_victim(plru_t t);
        if (!t[0]) begin
            return t[1] ? way_mask_t'(4'b0010) : way_mask_t'(4'b0001);
        end
        return t[2] ? way_mask_t'(4'b1000) : way_mask_t'(4'b0100);
    endfunction

    // point the tree away from the way just filled
    function automatic plru_t plru_fill(plru_t t, way_mask_t w);
        plru_t n;
        case (w)
            4'b0001: n = {t[2], 2'b11};
            4'b0010: n = {t[2], 2'b01};
            4'b0100: n = {1'b1, t[1], 1'b0};
            4'b1000: n = {1'b0, t[1], 1'b0};
            default: n = t;
        endcase
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // cpu handshake
    ////////////////////////////////////////////////////////////////////////////

    assign data_ok  = (state == st_run) && ds_valid && (ds_hit != '0);
    assign ds_miss  = (state == st_run) && ds_valid && (ds_hit == '0);
    assign ds_adv   = (state == st_run) && (!ds_valid || data_ok);
    assign index_ok = req && ds_adv;
    assign rdata    = ds_data;

    // pick the hitting way's half
    always_comb begin
        hit_half = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_half = hit_half | half_data[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ts_valid <= 1'b0;
        end else if (index_ok) begin
            ts_valid <= 1'b1;
        end else if (ds_adv) begin
            ts_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (index_ok) begin
            ts_lookup <= index;
        end
    end

    // replay refreshes the hit and data of the request that missed
    always_ff @(posedge clk) begin
        if (!rst) begin
            ds_valid <= 1'b0;
            ds_hit   <= '0;
        end else if (ds_adv) begin
            ds_valid <= ts_valid;
            ds_hit   <= ts_valid ? hit : '0;
        end else if (state == st_replay) begin
            ds_hit <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_adv) begin
            ds_lookup <= ts_lookup;
            ds_tag    <= tag;
            ds_data   <= hit_half;
        end else if (state == st_replay) begin
            ds_data <= hit_half;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // state machine and reset sweep
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_reset;
        end else begin
            case (state)
                st_reset:  state <= (reset_cnt == set_bits'(num_sets - 1)) ? st_run : st_reset;
                st_run:    state <= ds_miss ? st_miss : st_run;
                st_miss:   state <= arready ? st_refill : st_miss;
                st_refill: state <= (beat && rlast) ? st_finish : st_refill;
                st_finish: state <= st_replay;
                st_replay: state <= st_run;
                default:   state <= st_reset;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            reset_cnt <= '0;
        end else if (state == st_reset) begin
            reset_cnt <= reset_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // victim choice and refill
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= '0;
        end else if (ds_miss) begin
            victim <= plru_victim(plru[ds_lookup.set_idx]);
        end
    end

    // trees cleared by the sweep, touched again only by fills
    always_ff @(posedge clk) begin
        if (state == st_reset) begin
            plru[reset_cnt] <= '0;
        end else if (state == st_finish) begin
            plru[ds_lookup.set_idx] <= plru_fill(plru[ds_lookup.set_idx], victim);
        end
    end

    assign beat = rvalid && rready;

    // wrap burst starts at the requested half
    always_ff @(posedge clk) begin
        if (!rst) begin
            fill_cnt <= '0;
        end else if (ds_miss) begin
            fill_cnt <= {ds_lookup.half, 2'b00};
        end else if (beat) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            fill_buf[fill_cnt] <= rdata_bus;
        end
    end

    always_comb begin
        for (int i = 0; i < words_per_line; i++) begin
            fill_line[i*32 +: 32] = fill_buf[i];
        end
    end

    assign araddr  = {ds_tag, ds_lookup.set_idx, ds_lookup.half, 4'b0000};
    assign arvalid = (state == st_miss);
    assign rready  = (state == st_refill);

    ////////////////////////////////////////////////////////////////////////////
    // array access
    ////////////////////////////////////////////////////////////////////////////

    // finish reads the missed set back, replay re-reads the waiting tag stage
    always_comb begin
        tag_rd  = index;
        data_rd = index;
        case (state)
            st_miss, st_refill, st_finish: begin
                tag_rd  = ds_lookup;
                data_rd = ds_lookup;
            end
            st_replay: begin
                tag_rd  = ts_lookup;
                data_rd = ts_lookup;
            end
            default: begin
                tag_rd  = index;
                data_rd = index;
            end
        endcase
    end

    assign cmp_tag = (state == st_replay) ? ds_tag : tag;

    always_comb begin
        tag_wr         = '0;
        tag_wr.set_idx = ds_lookup.set_idx;
        tag_wr.tag     = ds_tag;
        tag_wr.valid   = 1'b1;
        if (state == st_reset) begin
            tag_wr.ways    = '1;
            tag_wr.set_idx = reset_cnt;
            tag_wr.tag     = '0;
            tag_wr.valid   = 1'b0;
        end else if (state == st_finish) begin
            tag_wr.ways = victim;
        end
    end

    assign data_wr.ways    = (state == st_finish) ? victim : '0;
    assign data_wr.set_idx = ds_lookup.set_idx;
    assign data_wr.line    = fill_line;

    // one victim way per fill
    assert property (@(posedge clk) disable iff (!rst)
        (state == st_finish) |-> $onehot(tag_wr.ways))
        else $error("miss_ctrl: fill way mask %b is not one-hot", tag_wr.ways);

    // address held until the slave takes it
    assert property (@(posedge clk) disable iff (!rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else $error("miss_ctrl: araddr changed before arready");

    // beats only land during a refill
    assert property (@(posedge clk) disable iff (!rst)
        (rvalid && rready) |-> (state == st_refill))
        else $error("miss_ctrl: read beat taken outside refill");

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // cpu side
    input  logic                 req,
    input  lookup_t              index,
    input  logic [tag_bits-1:0]  tag,
    output logic                 index_ok,
    output logic                 data_ok,
    output logic [half_bits-1:0] rdata,
    // axi read channel
    output logic [31:0]          araddr,
    output logic                 arvalid,
    input  logic                 arready,
    input  logic [31:0]          rdata_bus,
    input  logic                 rvalid,
    input  logic                 rlast,
    output logic                 rready
);

    // tag side
    lookup_t             tag_rd;
    logic [tag_bits-1:0] cmp_tag;
    tag_write_t          tag_wr;
    way_mask_t           hit;

    // data side
    lookup_t                            data_rd;
    data_write_t                        data_wr;
    logic [num_ways-1:0][half_bits-1:0] half_data;

    tag_ways tag_ways_inst (
        .clk     (clk),
        .rd      (tag_rd),
        .cmp_tag (cmp_tag),
        .wr      (tag_wr),
        .hit     (hit)
    );

    data_ways data_ways_inst (
        .clk       (clk),
        .rd        (data_rd),
        .wr        (data_wr),
        .half_data (half_data)
    );

    miss_ctrl miss_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .index     (index),
        .tag       (tag),
        .index_ok  (index_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_bus (rdata_bus),
        .rvalid    (rvalid),
        .rlast     (rlast),
        .rready    (rready),
        .tag_rd    (tag_rd),
        .cmp_tag   (cmp_tag),
        .tag_wr    (tag_wr),
        .hit       (hit),
        .data_rd   (data_rd),
        .data_wr   (data_wr),
        .half_data (half_data)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // low across the first two rising edges, released on a falling edge
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    typedef struct packed {
        logic [set_bits-1:0] set_idx;
        logic                half;
        logic [tag_bits-1:0] tag;
        logic                hit;
    } entry_t;

    localparam logic [31:0] pattern_key = 32'h5a5a0000;

    logic                 clk, rst, req, index_ok, data_ok;
    logic                 arvalid, arready, rvalid, rlast, rready;
    lookup_t              index;
    logic [tag_bits-1:0]  tag;
    logic [half_bits-1:0] rdata;
    logic [31:0]          araddr, rdata_bus;

    entry_t              table_q [$];
    int                  pend_q [$];
    int                  acc_q [$];
    logic [tag_bits-1:0] model_tag [num_sets][num_ways];
    logic                model_valid [num_sets][num_ways];
    plru_t               model_plru [num_sets];
    logic [tag_bits-1:0] cur_tag;
    logic [31:0]         burst_addr;
    integer              seed = 32'h9f29;
    bit                  miss_seen, ar_armed, burst_active, beat_taken, prev_hit;
    int                  cycle, cycle_limit, next_entry, done_count, last_miss_cycle;
    int                  prev_acc, prev_done_cycle;
    int                  ar_delay, beat_idx;
    int                  data_errs, addr_errs, hit_errs, lat_errs, other_errs;

    tb_clock tb_clock_inst (
        .clk (clk),
        .rst (rst)
    );

    icache_top icache_top_inst (.*);

    ////////////////////////////////////////////////////////////////////////////
    // reference model of tags and tree PLRU
    ////////////////////////////////////////////////////////////////////////////

    function automatic int pick_victim(plru_t t);
        if (!t[0]) begin
            return t[1] ? 1 : 0;
        end
        return t[2] ? 3 : 2;
    endfunction

    function automatic plru_t after_fill(plru_t t, int w);
        plru_t n;
        n = t;
        case (w)
            0: n[1:0] = 2'b11;
            1: n[1:0] = 2'b01;
            2: {n[2], n[0]} = 2'b10;
            default: {n[2], n[0]} = 2'b00;
        endcase
        return n;
    endfunction

    // returns the hit, fills the victim way on a miss
    function automatic bit model_access(entry_t e);
        int v;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[e.set_idx][w] && (model_tag[e.set_idx][w] == e.tag)) begin
                return 1'b1;
            end
        end
        v = pick_victim(model_plru[e.set_idx]);
        model_tag[e.set_idx][v]   = e.tag;
        model_valid[e.set_idx][v] = 1'b1;
        model_plru[e.set_idx]     = after_fill(model_plru[e.set_idx], v);
        return 1'b0;
    endfunction

    function automatic logic [31:0] half_addr(entry_t e);
        return {e.tag, e.set_idx, e.half, 4'b0000};
    endfunction

    // memory word at byte address a is a ^ pattern_key
    function automatic logic [half_bits-1:0] expect_half(logic [31:0] base);
        logic [half_bits-1:0] h;
        for (int k = 0; k < 4; k++) begin
            h[32*k +: 32] = (base + 32'(4 * k)) ^ pattern_key;
        end
        return h;
    endfunction

    task automatic add_entry(int s, bit h, logic [tag_bits-1:0] t, bit exp_hit);
        table_q.push_back({set_bits'(s), h, t, exp_hit});
    endtask

    task automatic check_half(logic [half_bits-1:0] got, logic [half_bits-1:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: rdata %h, expected %h", $time, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_addr(logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: araddr %h, expected %h", $time, got, exp);
            addr_errs++;
        end
    endtask

    task automatic check_hit(bit got, bit exp);
        if (got != exp) begin
            $display("Fail at time %0t: request %s, expected %s", $time,
                     got ? "hit" : "missed", exp ? "a hit" : "a miss");
            hit_errs++;
        end
    endtask

    task automatic check_latency(int got, int exp);
        if (got != exp) begin
            $display("Fail at time %0t: hit latency %0d cycles, expected %0d", $time, got, exp);
            lat_errs++;
        end
    endtask

    task automatic check_spacing(int got, int exp);
        if (got != exp) begin
            $display("Fail at time %0t: data_ok %0d cycles after the previous hit, expected %0d",
                     $time, got, exp);
            lat_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per-cycle drive and observe
    ////////////////////////////////////////////////////////////////////////////

    // the accepted tag is held until the next acceptance
    task automatic drive_cpu();
        tag = cur_tag;
        req = (next_entry < table_q.size());
        if (req) begin
            index.set_idx = table_q[next_entry].set_idx;
            index.half    = table_q[next_entry].half;
        end
    endtask

    task automatic drive_axi();
        if (arvalid && !ar_armed) begin
            ar_armed = 1'b1;
            ar_delay = $random(seed) & 3;
        end
        arready = ar_armed && (ar_delay == 0);
        if (ar_armed && (ar_delay > 0)) begin
            ar_delay--;
        end
        // an offered beat stays until taken
        if (burst_active && (!rvalid || beat_taken)) begin
            rvalid    = ($random(seed) & 3) != 0;
            rdata_bus = {burst_addr[31:5], 3'(burst_addr[4:2] + beat_idx), 2'b00} ^ pattern_key;
            rlast     = (beat_idx == words_per_line - 1);
        end else if (!burst_active) begin
            rvalid = 1'b0;
            rlast  = 1'b0;
        end
    endtask

    // values seen here are the ones the DUT samples on the coming rising edge
    task automatic observe();
        entry_t e;
        int     acc;
        if (req && index_ok) begin
            pend_q.push_back(next_entry);
            acc_q.push_back(cycle);
            cur_tag = table_q[next_entry].tag;
            next_entry++;
        end
        if (arvalid && !miss_seen) begin
            miss_seen       = 1'b1;
            last_miss_cycle = cycle;
        end
        if (arvalid && arready) begin
            if (pend_q.size() == 0) begin
                $display("AXI read request at time %0t with no CPU request waiting", $time);
                other_errs++;
            end else begin
                check_addr(araddr, half_addr(table_q[pend_q[0]]));
            end
            ar_armed     = 1'b0;
            burst_active = 1'b1;
            burst_addr   = araddr;
            beat_idx     = 0;
        end
        beat_taken = rvalid && rready;
        if (beat_taken) begin
            beat_idx++;
            burst_active = (beat_idx < words_per_line);
        end
        if (data_ok) begin
            if (pend_q.size() == 0) begin
                $display("data_ok at time %0t with no CPU request waiting", $time);
                other_errs++;
            end else begin
                e   = table_q[pend_q.pop_front()];
                acc = acc_q.pop_front();
                check_half(rdata, expect_half(half_addr(e)));
                check_hit(!miss_seen, e.hit);
                // no miss since acceptance, so the pipeline ran freely
                if (e.hit && (last_miss_cycle < acc)) begin
                    check_latency(cycle - acc, 2);
                end
                // back-to-back hits return on consecutive cycles
                if (e.hit && prev_hit && (last_miss_cycle < prev_acc)) begin
                    check_spacing(cycle - prev_done_cycle, 1);
                end
                prev_hit        = e.hit;
                prev_acc        = acc;
                prev_done_cycle = cycle;
                miss_seen = 1'b0;
                done_count++;
            end
        end
    endtask

    initial begin
        req       = 1'b0;
        index     = '0;
        tag       = '0;
        cur_tag   = '0;
        arready   = 1'b0;
        rdata_bus = '0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        last_miss_cycle = -1;

        // set, half, tag, expected hit
        add_entry(5, 0, 20'h12345, 0);
        add_entry(5, 0, 20'h12345, 1);
        add_entry(5, 0, 20'h12345, 1);
        add_entry(5, 1, 20'h12345, 1);
        add_entry(5, 0, 20'h12345, 1);
        add_entry(5, 1, 20'h12345, 1);
        add_entry(20, 0, 20'h10000, 0);
        add_entry(20, 1, 20'h20000, 0);
        add_entry(20, 0, 20'h30000, 0);
        add_entry(20, 1, 20'h40000, 0);
        add_entry(20, 0, 20'h50000, 0);
        add_entry(20, 0, 20'h20000, 1);
        add_entry(20, 1, 20'h30000, 1);
        add_entry(20, 0, 20'h40000, 1);
        add_entry(20, 1, 20'h50000, 1);
        add_entry(20, 0, 20'h10000, 0);
        add_entry(127, 1, 20'hfffff, 0);
        add_entry(0, 0, 20'h00000, 0);
        add_entry(0, 0, 20'h00000, 1);
        cycle_limit = 2 * table_q.size() * 40 + 200;

        for (int s = 0; s < num_sets; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        foreach (table_q[i]) begin
            if (model_access(table_q[i]) != table_q[i].hit) begin
                $display("table entry %0d does not match the cache model", i);
                other_errs++;
            end
        end

        wait (rst === 1'b1);
        // a request is already waiting while the sweep runs
        drive_cpu();
        #1;
        if ((index_ok !== 1'b0) || (data_ok !== 1'b0) || (arvalid !== 1'b0) ||
            (rready !== 1'b0)) begin
            $display("Fail at time %0t: handshake outputs not low after reset", $time);
            other_errs++;
        end

        while ((done_count < table_q.size()) && (cycle < cycle_limit)) begin
            @(negedge clk);
            drive_cpu();
            drive_axi();
            #1;
            observe();
            cycle++;
        end
        if (done_count < table_q.size()) begin
            $display("timeout: only %0d of %0d requests returned data within %0d cycles",
                     done_count, table_q.size(), cycle_limit);
            other_errs++;
        end

        $display("errors: data %0d, address %0d, hit %0d, latency %0d, other %0d",
                 data_errs, addr_errs, hit_errs, lat_errs, other_errs);
        if ((data_errs + addr_errs + hit_errs + lat_errs + other_errs) == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: all.f
src/icache_pkg.sv
src/tag_ways.sv
src/data_ways.sv
src/miss_ctrl.sv
src/icache_top.sv
tb/tb_clock.sv
tb/icache_tb.sv
